/* tl_bios_pkg.sv */
package tl_bios_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    localparam int XLEN   = 32;         // Data width of A and D channels
    localparam int STRB_W = XLEN / 8;   // One mask bit per byte lane
    localparam int SID_W  = 2;          // Source ID width
    localparam int ADDR_W = 32;

    //////////////////////////////
    // Memory geometry
    //////////////////////////////

    localparam int BIOS_BYTES = 128;
    localparam int MEM_IDX_W  = $clog2(BIOS_BYTES);  // Byte index, 7 bits

    // Image loaded into the array at start of simulation
    localparam string BIOS_FILE = "bios.hex";

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    // A channel requests
    localparam logic [2:0] OP_GET      = 3'd4;
    localparam logic [2:0] OP_PUT_FULL = 3'd0;

    // D channel responses
    localparam logic [2:0] OP_ACK      = 3'd0;
    localparam logic [2:0] OP_ACK_DATA = 3'd1;

    //////////////////////////////
    // Size codes
    //////////////////////////////

    // log2 of the byte count, as carried on a_size and d_size
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

endpackage

/* tl_req_decode.sv */
`timescale 1ns/1ps

module tl_req_decode (
    input  logic                                 clk,
    input  logic                                 reset,

    // A channel
    input  logic                                 a_valid,
    output logic                                 a_ready,
    input  logic [2:0]                           a_opcode,
    input  logic [2:0]                           a_size,
    input  logic [tl_bios_pkg::SID_W-1:0]        a_source,
    input  logic [tl_bios_pkg::ADDR_W-1:0]       a_address,
    input  logic [tl_bios_pkg::STRB_W-1:0]       a_mask,
    input  logic [tl_bios_pkg::XLEN-1:0]         a_data,

    // To memory stage
    output logic                                 acc_start,
    output logic                                 acc_write,
    output logic [tl_bios_pkg::MEM_IDX_W-3:0]    acc_word_idx,
    output logic [1:0]                           acc_lane,
    output logic [2:0]                           acc_size,
    output logic [tl_bios_pkg::STRB_W-1:0]       acc_mask,
    output logic [tl_bios_pkg::XLEN-1:0]         acc_wdata,

    // To response stage
    output logic                                 deny_start,
    output logic [tl_bios_pkg::SID_W-1:0]        req_source,
    output logic [2:0]                           req_size,
    output logic                                 req_write,
    input  logic                                 resp_taken
);

    import tl_bios_pkg::*;

    logic              accept;
    logic              busy;      // Request held until its response is taken
    logic              pending;   // Accepted last cycle, strobe goes out now
    logic              deny;
    logic              deny_q;
    logic              bad_op, bad_size, misaligned, past_end, bad_mask;
    logic [ADDR_W:0]   end_addr;  // One past the last byte touched

    // Byte lanes covered by an access of this size at this lane
    function automatic logic [STRB_W-1:0] lane_mask(input logic [1:0] lane,
                                                     input logic [2:0] size);
        logic [STRB_W-1:0] m;
        case (size)
            SIZE_BYTE: m = 4'b0001;
            SIZE_HALF: m = 4'b0011;
            SIZE_WORD: m = 4'b1111;
            default:   m = 4'b0000;
        endcase
        return m << lane;
    endfunction

    assign accept = a_valid & a_ready;

    //////////////////////////////
    // Deny rules
    //////////////////////////////

    assign bad_op   = (a_opcode != OP_GET) && (a_opcode != OP_PUT_FULL);
    assign bad_size = (a_size > SIZE_WORD);
    assign end_addr = {1'b0, a_address} + ({{ADDR_W{1'b0}}, 1'b1} << a_size);
    assign past_end = (end_addr > (ADDR_W+1)'(BIOS_BYTES));

    always_comb begin
        case (a_size)
            SIZE_HALF: misaligned = a_address[0];
            SIZE_WORD: misaligned = |a_address[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // Only checked for writes, a Get ignores its mask
    assign bad_mask = (a_opcode == OP_PUT_FULL) &&
                      (a_mask != lane_mask(a_address[1:0], a_size));

    assign deny = bad_op | bad_size | misaligned | past_end | bad_mask;

    //////////////////////////////
    // Handshake and strobes
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            a_ready    <= 1'b0;
            pending    <= 1'b0;
            deny_q     <= 1'b0;
            acc_start  <= 1'b0;
            deny_start <= 1'b0;
        end else begin
            acc_start  <= pending & ~deny_q;
            deny_start <= pending & deny_q;
            pending    <= accept;
            if (accept) begin
                busy    <= 1'b1;
                a_ready <= 1'b0;
                deny_q  <= deny;
            end else if (resp_taken) begin
                busy    <= 1'b0;
                a_ready <= 1'b1;
            end else begin
                a_ready <= ~busy;   // Comes up on first edge out of reset
            end
        end
    end

    // Request fields, held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_write    <= (a_opcode == OP_PUT_FULL);
            acc_word_idx <= a_address[MEM_IDX_W-1:2];
            acc_lane     <= a_address[1:0];
            acc_size     <= a_size;
            acc_mask     <= a_mask;
            acc_wdata    <= a_data;
            req_source   <= a_source;
        end
    end

    assign req_size  = acc_size;
    assign req_write = acc_write;

endmodule

/* bios_mem_access.sv */
`timescale 1ns/1ps

module bios_mem_access (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic                                 acc_start,
    input  logic                                 acc_write,
    input  logic [tl_bios_pkg::MEM_IDX_W-3:0]    acc_word_idx,
    input  logic [1:0]                           acc_lane,
    input  logic [2:0]                           acc_size,
    input  logic [tl_bios_pkg::STRB_W-1:0]       acc_mask,
    input  logic [tl_bios_pkg::XLEN-1:0]         acc_wdata,

    output logic                                 acc_done,
    output logic [tl_bios_pkg::XLEN-1:0]         rdata
);

    import tl_bios_pkg::*;

    // BIOS image, one byte per entry
    logic [7:0] mem [0:BIOS_BYTES-1];

    initial begin
        $readmemh(BIOS_FILE, mem);
    end

    logic                  active;
    logic                  phase_wb;    // 0 fetch, 1 write-back
    logic [1:0]            part;        // Byte of the word handled this cycle
    logic                  step;
    logic                  last;
    logic [MEM_IDX_W-1:0]  byte_addr;

    logic [XLEN-1:0]       word_q;      // Bytes gathered so far
    logic [XLEN-1:0]       fetch_word;
    logic [XLEN-1:0]       wdata_sh;
    logic [XLEN-1:0]       merged;
    logic [XLEN-1:0]       rd_shift;
    logic [XLEN-1:0]       rd_word;

    // acc_ fields stay put for the whole access since a_ready is low
    assign step      = acc_start | active;
    assign last      = (part == 2'd3);
    assign byte_addr = {acc_word_idx, part};

    //////////////////////////////
    // Fetch and merge
    //////////////////////////////

    // Word as it stands after this cycle's byte lands
    always_comb begin
        fetch_word = word_q;
        fetch_word[8*part +: 8] = mem[byte_addr];
    end

    // Write data arrives low-justified
    assign wdata_sh = acc_wdata << (8 * acc_lane);

    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            merged[8*i +: 8] = acc_mask[i] ? wdata_sh[8*i +: 8] : word_q[8*i +: 8];
        end
    end

    //////////////////////////////
    // Read extraction
    //////////////////////////////

    assign rd_shift = fetch_word >> (8 * acc_lane);

    always_comb begin
        case (acc_size)
            SIZE_BYTE: rd_word = {24'b0, rd_shift[7:0]};
            SIZE_HALF: rd_word = {16'b0, rd_shift[15:0]};
            default:   rd_word = rd_shift;
        endcase
    end

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            phase_wb <= 1'b0;
            part     <= 2'd0;
            acc_done <= 1'b0;
        end else begin
            acc_done <= 1'b0;
            if (step) begin
                part <= part + 2'd1;    // Wraps to 0 after the last byte
                if (!last) begin
                    active <= 1'b1;
                end else if (!phase_wb && acc_write) begin
                    // Word complete, go write it back
                    phase_wb <= 1'b1;
                    active   <= 1'b1;
                end else begin
                    phase_wb <= 1'b0;
                    active   <= 1'b0;
                    acc_done <= 1'b1;
                end
            end
        end
    end

    // Gathered word and result
    always_ff @(posedge clk) begin
        if (step && !phase_wb) begin
            word_q <= fetch_word;
        end
        if (step && last) begin
            rdata <= acc_write ? '0 : rd_word;  // Writes return no data
        end
    end

    // Write-back, one byte per cycle
    always_ff @(posedge clk) begin
        if (step && phase_wb) begin
            mem[byte_addr] <= merged[8*part +: 8];
        end
    end

endmodule

/* tl_resp_drive.sv */
`timescale 1ns/1ps

module tl_resp_drive (
    input  logic                              clk,
    input  logic                              reset,

    // From memory stage
    input  logic                              acc_done,
    input  logic [tl_bios_pkg::XLEN-1:0]      rdata,

    // From decode stage
    input  logic                              deny_start,
    input  logic [tl_bios_pkg::SID_W-1:0]     req_source,
    input  logic [2:0]                        req_size,
    input  logic                              req_write,
    output logic                              resp_taken,

    // D channel
    output logic                              d_valid,
    input  logic                              d_ready,
    output logic [2:0]                        d_opcode,
    output logic [2:0]                        d_size,
    output logic [tl_bios_pkg::SID_W-1:0]     d_source,
    output logic [tl_bios_pkg::XLEN-1:0]      d_data,
    output logic                              d_denied
);

    import tl_bios_pkg::*;

    logic resp_load;   // Either strobe starts a response
    logic xfer;        // D beat taken this edge

    assign resp_load = acc_done | deny_start;
    assign xfer      = d_valid & d_ready;

    //////////////////////////////
    // Valid and denied flag
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_valid    <= 1'b0;
            d_denied   <= 1'b0;
            resp_taken <= 1'b0;
        end else begin
            resp_taken <= 1'b0;
            if (resp_load) begin
                d_valid  <= 1'b1;
                d_denied <= deny_start;
            end else if (xfer) begin
                d_valid    <= 1'b0;
                d_denied   <= 1'b0;
                resp_taken <= 1'b1;     // Lets decode raise a_ready next edge
            end
        end
    end

    //////////////////////////////
    // Response fields
    //////////////////////////////

    // Loaded once per request, so they stay still through any stall
    always_ff @(posedge clk) begin
        if (resp_load) begin
            d_opcode <= req_write ? OP_ACK : OP_ACK_DATA;
            d_size   <= req_size;
            d_source <= req_source;
            d_data   <= deny_start ? '0 : rdata;
        end
    end

endmodule

/* tl_ul_bios.sv */
`timescale 1ns/1ps

module tl_ul_bios (
    input  logic                              clk,
    input  logic                              reset,

    // A channel
    input  logic                              a_valid,
    output logic                              a_ready,
    input  logic [2:0]                        a_opcode,
    input  logic [2:0]                        a_size,
    input  logic [tl_bios_pkg::SID_W-1:0]     a_source,
    input  logic [tl_bios_pkg::ADDR_W-1:0]    a_address,
    input  logic [tl_bios_pkg::STRB_W-1:0]    a_mask,
    input  logic [tl_bios_pkg::XLEN-1:0]      a_data,

    // D channel
    output logic                              d_valid,
    input  logic                              d_ready,
    output logic [2:0]                        d_opcode,
    output logic [2:0]                        d_size,
    output logic [tl_bios_pkg::SID_W-1:0]     d_source,
    output logic [tl_bios_pkg::XLEN-1:0]      d_data,
    output logic                              d_denied
);

    import tl_bios_pkg::*;

    // Decode to memory
    logic                  acc_start;
    logic                  acc_write;
    logic [MEM_IDX_W-3:0]  acc_word_idx;
    logic [1:0]            acc_lane;
    logic [2:0]            acc_size;
    logic [STRB_W-1:0]     acc_mask;
    logic [XLEN-1:0]       acc_wdata;

    // Decode to response
    logic                  deny_start;
    logic [SID_W-1:0]      req_source;
    logic [2:0]            req_size;
    logic                  req_write;

    // Memory to response, and back to decode
    logic                  acc_done;
    logic [XLEN-1:0]       rdata;
    logic                  resp_taken;

    tl_req_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .a_valid      (a_valid),
        .a_ready      (a_ready),
        .a_opcode     (a_opcode),
        .a_size       (a_size),
        .a_source     (a_source),
        .a_address    (a_address),
        .a_mask       (a_mask),
        .a_data       (a_data),
        .acc_start    (acc_start),
        .acc_write    (acc_write),
        .acc_word_idx (acc_word_idx),
        .acc_lane     (acc_lane),
        .acc_size     (acc_size),
        .acc_mask     (acc_mask),
        .acc_wdata    (acc_wdata),
        .deny_start   (deny_start),
        .req_source   (req_source),
        .req_size     (req_size),
        .req_write    (req_write),
        .resp_taken   (resp_taken)
    );

    bios_mem_access u_mem (
        .clk          (clk),
        .reset        (reset),
        .acc_start    (acc_start),
        .acc_write    (acc_write),
        .acc_word_idx (acc_word_idx),
        .acc_lane     (acc_lane),
        .acc_size     (acc_size),
        .acc_mask     (acc_mask),
        .acc_wdata    (acc_wdata),
        .acc_done     (acc_done),
        .rdata        (rdata)
    );

    tl_resp_drive u_resp (
        .clk          (clk),
        .reset        (reset),
        .acc_done     (acc_done),
        .rdata        (rdata),
        .deny_start   (deny_start),
        .req_source   (req_source),
        .req_size     (req_size),
        .req_write    (req_write),
        .resp_taken   (resp_taken),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .d_opcode     (d_opcode),
        .d_size       (d_size),
        .d_source     (d_source),
        .d_data       (d_data),
        .d_denied     (d_denied)
    );

endmodule

/* tl_ul_bios_asserts.sv */
`timescale 1ns/1ps

module tl_ul_bios_asserts (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              a_ready,
    input  logic                              d_valid,
    input  logic                              d_ready,
    input  logic [2:0]                        d_opcode,
    input  logic [2:0]                        d_size,
    input  logic [tl_bios_pkg::SID_W-1:0]     d_source,
    input  logic [tl_bios_pkg::XLEN-1:0]      d_data,
    input  logic                              d_denied
);

    import tl_bios_pkg::*;

    //////////////////////////////
    // D channel
    //////////////////////////////

    // Stalled response must not move
    d_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        d_valid && !d_ready |=> d_valid && $stable(d_opcode) && $stable(d_size) &&
                                $stable(d_source) && $stable(d_data) && $stable(d_denied)
    ) else $error("D channel changed while stalled");

    // Denied responses carry no data
    deny_zero_a: assert property (
        @(posedge clk) disable iff (reset)
        d_valid && d_denied |-> d_data == '0
    ) else $error("Denied response with nonzero data");

    //////////////////////////////
    // Handshake
    //////////////////////////////

    // One request in flight
    busy_a: assert property (
        @(posedge clk) disable iff (reset)
        d_valid |-> !a_ready
    ) else $error("a_ready high while a response is pending");

    reset_a: assert property (
        @(posedge clk) reset |-> !a_ready && !d_valid
    ) else $error("a_ready or d_valid high during reset");

endmodule

bind tl_ul_bios tl_ul_bios_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .a_ready  (a_ready),
    .d_valid  (d_valid),
    .d_ready  (d_ready),
    .d_opcode (d_opcode),
    .d_size   (d_size),
    .d_source (d_source),
    .d_data   (d_data),
    .d_denied (d_denied)
);

/* tb_tl_ul_bios.sv */
`timescale 1ns/1ps

module tb_tl_ul_bios;

    import tl_bios_pkg::*;

    localparam logic [31:0] SEED       = 32'hbd64_a55d;
    localparam int          CLK_PERIOD = 8;
    localparam int          NUM_REQ    = 200;
    localparam int          TIMEOUT_NS = NUM_REQ * 40 * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              a_valid, a_ready;
    logic [2:0]        a_opcode, a_size;
    logic [SID_W-1:0]  a_source;
    logic [ADDR_W-1:0] a_address;
    logic [STRB_W-1:0] a_mask;
    logic [XLEN-1:0]   a_data;
    logic              d_valid, d_ready;
    logic [2:0]        d_opcode, d_size;
    logic [SID_W-1:0]  d_source;
    logic [XLEN-1:0]   d_data;
    logic              d_denied;

    logic [7:0]        model [0:BIOS_BYTES-1];   // Reference copy of the memory

    // Expected responses, oldest first
    logic [2:0]        q_op[$];
    logic [2:0]        q_size[$];
    logic [SID_W-1:0]  q_src[$];
    logic [XLEN-1:0]   q_data[$];
    logic              q_den[$];

    int                sent;
    int                stall_left;
    logic [31:0]       stim_rng;
    logic [31:0]       stall_rng;

    tl_ul_bios i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lanes that nbytes bytes starting at lane occupy
    function automatic logic [3:0] lanes_for(input logic [1:0] lane, input int nbytes);
        logic [3:0] m;
        m = 4'((32'd1 << nbytes) - 1);
        return m << lane;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0d ns: %s is %h, expected %h", $time, field, got, exp);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    //////////////////////////////
    // Request driver and model
    //////////////////////////////

    task automatic issue(input logic [2:0] op, input logic [2:0] size,
                         input logic [SID_W-1:0] src, input logic [31:0] addr,
                         input logic [3:0] mask, input logic [31:0] data);
        logic        deny;
        int          nbytes;
        logic [32:0] end_a;
        logic [31:0] rd;
        nbytes = (size <= SIZE_WORD) ? (1 << size) : 0;
        end_a  = {1'b0, addr} + (33'd1 << size);
        deny   = (op != OP_GET && op != OP_PUT_FULL) || (size > SIZE_WORD) ||
                 (end_a > 33'(BIOS_BYTES));
        if (!deny && (addr % nbytes) != 0)
            deny = 1'b1;
        if (!deny && op == OP_PUT_FULL && mask != lanes_for(addr[1:0], nbytes))
            deny = 1'b1;
        a_valid   = 1'b1;
        a_opcode  = op;
        a_size    = size;
        a_source  = src;
        a_address = addr;
        a_mask    = mask;
        a_data    = data;
        while (!a_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);           // Accept edge
        rd = '0;
        if (!deny) begin
            for (int k = 0; k < nbytes; k++) begin
                if (op == OP_GET)
                    rd[8*k +: 8] = model[7'(addr[6:0] + k)];
                else
                    model[7'(addr[6:0] + k)] = data[8*k +: 8];
            end
        end
        q_op.push_back((op == OP_PUT_FULL) ? OP_ACK : OP_ACK_DATA);
        q_size.push_back(size);
        q_src.push_back(src);
        q_data.push_back(rd);
        q_den.push_back(deny);
        sent++;
        #1;
        a_valid = 1'b0;
    endtask

    task automatic issue_random();
        logic [31:0] r, r2, r3;
        logic [2:0]  op, size;
        logic [31:0] addr;
        logic [3:0]  mask;
        stim_rng = lcg_next(stim_rng);
        r        = stim_rng;
        stim_rng = lcg_next(stim_rng);
        r2       = stim_rng;
        stim_rng = lcg_next(stim_rng);
        r3       = stim_rng;
        if (r[31:29] == 3'd0)
            op = r[10:8];                        // Occasionally any opcode
        else
            op = r[28] ? OP_PUT_FULL : OP_GET;
        size = (r[27:25] == 3'd0) ? 3'd3 : 3'(r[24:23] % 3);
        addr = (r2[31:28] == 4'd0) ? r2 : {25'b0, r2[6:0]};
        if (r2[27:25] != 3'd0 && size <= SIZE_WORD)
            addr = addr & ~((32'd1 << size) - 1);
        if (r2[24:22] == 3'd0 || size > SIZE_WORD)
            mask = r2[13:10];
        else
            mask = lanes_for(addr[1:0], 1 << size);
        issue(op, size, r[1:0], addr, mask, r3);
    endtask

    //////////////////////////////
    // Response checks
    //////////////////////////////

    always @(posedge clk) begin
        if (!reset && d_valid && d_ready) begin
            if (q_op.size() == 0) begin
                fail_run("A response arrived with no request outstanding");
            end else begin
                assert (d_opcode == q_op[0])
                    else report_mismatch("d_opcode", 32'(d_opcode), 32'(q_op[0]));
                assert (d_size == q_size[0])
                    else report_mismatch("d_size", 32'(d_size), 32'(q_size[0]));
                assert (d_source == q_src[0])
                    else report_mismatch("d_source", 32'(d_source), 32'(q_src[0]));
                assert (d_denied == q_den[0])
                    else report_mismatch("d_denied", 32'(d_denied), 32'(q_den[0]));
                assert (d_data == q_data[0]) else report_mismatch("d_data", d_data, q_data[0]);
                void'(q_op.pop_front());
                void'(q_size.pop_front());
                void'(q_src.pop_front());
                void'(q_data.pop_front());
                void'(q_den.pop_front());
            end
        end
    end

    // Random back-pressure in stretches of up to 8 cycles
    initial begin
        d_ready    = 1'b0;
        stall_left = 0;
        stall_rng  = SEED ^ 32'h5a5a_0f0f;
        @(negedge reset);
        forever begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                stall_left--;
                d_ready = 1'b0;
            end else begin
                stall_rng = lcg_next(stall_rng);
                if (stall_rng[31:30] == 2'd0) begin
                    stall_left = int'(stall_rng[18:16]);
                    d_ready    = 1'b0;
                end else begin
                    d_ready = 1'b1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("Timeout: the run did not finish in the allowed time");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        a_valid   = 1'b0;
        a_opcode  = '0;
        a_size    = '0;
        a_source  = '0;
        a_address = '0;
        a_mask    = '0;
        a_data    = '0;
        sent      = 0;
        stim_rng  = SEED;
        $readmemh(BIOS_FILE, model);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reads of each size
        issue(OP_GET, SIZE_WORD, 2'd0, 32'h00, 4'hf, '0);
        issue(OP_GET, SIZE_HALF, 2'd1, 32'h06, 4'hc, '0);
        issue(OP_GET, SIZE_BYTE, 2'd2, 32'h7f, 4'h8, '0);
        issue(OP_GET, SIZE_BYTE, 2'd3, 32'h41, 4'h2, '0);
        issue(OP_GET, SIZE_HALF, 2'd0, 32'h7e, 4'hc, '0);
        issue(OP_GET, SIZE_WORD, 2'd1, 32'h7c, 4'hf, '0);
        // Writes followed by readback of the whole word
        issue(OP_PUT_FULL, SIZE_BYTE, 2'd2, 32'h11, 4'b0010, 32'h0000_00a5);
        issue(OP_GET, SIZE_WORD, 2'd2, 32'h10, 4'hf, '0);
        issue(OP_PUT_FULL, SIZE_HALF, 2'd3, 32'h22, 4'b1100, 32'h0000_beef);
        issue(OP_GET, SIZE_WORD, 2'd3, 32'h20, 4'hf, '0);
        issue(OP_PUT_FULL, SIZE_WORD, 2'd0, 32'h30, 4'hf, 32'h1234_5678);
        issue(OP_GET, SIZE_WORD, 2'd0, 32'h30, 4'hf, '0);
        // Each deny rule, then check the word is untouched
        issue(3'd2, SIZE_WORD, 2'd1, 32'h40, 4'hf, 32'hdead_beef);
        issue(OP_GET, 3'd3, 2'd1, 32'h40, 4'hf, '0);
        issue(OP_GET, SIZE_WORD, 2'd2, 32'h41, 4'hf, '0);
        issue(OP_PUT_FULL, SIZE_HALF, 2'd2, 32'h43, 4'b1000, 32'h0000_5555);
        issue(OP_GET, SIZE_BYTE, 2'd3, 32'h80, 4'h1, '0);
        issue(OP_GET, SIZE_WORD, 2'd3, 32'h80, 4'hf, '0);
        issue(OP_PUT_FULL, SIZE_WORD, 2'd0, 32'h40, 4'b0111, 32'hcafe_f00d);
        issue(OP_PUT_FULL, SIZE_BYTE, 2'd0, 32'h40, 4'b0010, 32'h0000_0077);
        issue(OP_GET, SIZE_WORD, 2'd1, 32'h40, 4'hf, '0);

        while (sent < NUM_REQ)
            issue_random();

        while (q_op.size() != 0 || d_valid)
            @(posedge clk);
        repeat (2) @(posedge clk);
        if (!a_ready) begin
            fail_run("The DUT did not return to ready after the last response");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* bios.hex */
// 16 bytes per line, byte address 0 first
ea 5b e0 00 f0 31 c0 8e d8 8e c0 bc 00 7c fb fc
b8 03 00 cd 10 be 40 7c e8 12 00 eb fe 90 55 aa
ac 08 c0 74 09 b4 0e bb 07 00 cd 10 eb f2 c3 00
42 49 4f 53 20 72 65 61 64 79 0d 0a 00 11 22 33
44 55 66 77 88 99 aa bb cc dd ee ff 01 23 45 67
89 ab cd ef fe dc ba 98 76 54 32 10 0f 1e 2d 3c
4b 5a 69 78 87 96 a5 b4 c3 d2 e1 f0 13 57 9b df
24 68 ac e0 31 75 b9 fd 02 46 8a ce 5a a5 c3 3c

/* build.f */
tl_bios_pkg.sv
tl_req_decode.sv
bios_mem_access.sv
tl_resp_drive.sv
tl_ul_bios.sv
tl_ul_bios_asserts.sv
tb_tl_ul_bios.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TileLink BIOS memory testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_tl_ul_bios \
    -f build.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation finished without failure"
